/* agu_pkg.sv */
/*
 * Shared types for the 6502-style address generation unit.
 * Encodings of the datapath op fields are fixed, slices decode them directly.
 * Operand bytes are 8 bits, addresses 16 bits, no other widths supported.
 */
`default_nettype none

package agu_pkg;

    typedef enum logic [1:0] {
        mode_zpx,                      // zeropage,X
        mode_abs,                      // absolute
        mode_absx,                     // absolute,X
        mode_rel                       // relative branch
    } agu_mode_e;

    typedef enum logic [1:0] {
        op_reg,                        // REG + ci
        op_base_reg,                   // base + REG + ci
        op_base,                       // base + ci
        op_base_abl                    // base + ABL + ci
    } lo_op_e;

    typedef enum logic [1:0] {
        base_zero,
        base_pcl,
        base_ahl,
        base_db
    } lo_base_e;

    typedef enum logic [1:0] {
        hi_hold,                       // ABH + ci, sign fix if sfix
        hi_zero,                       // page from REG high, 00 for X modes
        hi_pch,                        // restore from PCH
        hi_ahh                         // AHH + ci
    } hi_op_e;

    typedef struct packed {
        agu_mode_e   mode;
        logic [15:0] pc;               // address of first operand byte
        logic [7:0]  x;                // index value
        logic        cond;             // branch taken
    } agu_cmd_t;

    typedef struct packed {
        lo_op_e   lo_op;
        lo_base_e lo_base;
        logic     ci;                  // carry into low adder
        logic     ld_ahl;
        logic     ld_ahh;
        logic     ld_pc;
        logic     inc_pc;
        hi_op_e   hi_op;
        logic     sfix;                // add sign of db to ABH
    } dp_ctrl_t;

    typedef union packed {
        logic [7:0]        abs;        // address byte
        logic signed [7:0] rel;        // branch offset
    } operand_u;

    typedef struct packed {
        logic        req;
        logic [15:0] adr;
    } wb_req_t;

endpackage

`default_nettype wire

/* abl.sv */
/*
 * Low address byte slice. Base select then offset adder, result registered in ABL.
 * co is the adder carry, only meaningful for ops that add to a base.
 * PCL steps from ABL, the sequencer keeps co equal to that carry on increments.
 */
`timescale 1ns/10ps
`default_nettype none

module abl (
    input  logic               clk,
    input  logic               rst_n,
    input  agu_pkg::dp_ctrl_t  ctrl,
    input  agu_pkg::operand_u  db,
    input  logic [7:0]         reg_val,
    output logic               co,
    output logic [7:0]         adl,
    output logic [7:0]         ab_lo
);

    import agu_pkg::*;

    logic [7:0] base;                  // stage one result
    logic [8:0] sum;                   // stage two result with carry
    logic [7:0] abl_q;                 // address bus low
    logic [7:0] ahl_q;                 // address hold low
    logic [7:0] pcl_q;                 // program counter low

    // stage one, base register
    always_comb begin
        case (ctrl.lo_base)
            base_zero: base = 8'h00;
            base_pcl:  base = pcl_q;
            base_ahl:  base = ahl_q;
            default:   base = db.abs;  // raw bus byte
        endcase
    end

    // stage two, offset plus carry in
    always_comb begin
        case (ctrl.lo_op)
            op_reg:      sum = {1'b0, reg_val} + 9'(ctrl.ci);
            op_base_reg: sum = {1'b0, base} + {1'b0, reg_val} + 9'(ctrl.ci);
            op_base:     sum = {1'b0, base} + 9'(ctrl.ci);
            default:     sum = {1'b0, base} + {1'b0, abl_q} + 9'(ctrl.ci);
        endcase
    end

    assign {co, adl} = sum;
    assign ab_lo     = abl_q;

    always_ff @(posedge clk) begin
        abl_q <= adl;                  // follows adder every cycle
        if (ctrl.ld_ahl)
            ahl_q <= db.abs;           // first operand byte
        if (ctrl.ld_pc)
            pcl_q <= abl_q + 8'(ctrl.inc_pc);
    end

    // sequencer must never leave control floating
    ctrl_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(ctrl));

endmodule

`default_nettype wire

/* abh.sv */
/*
 * High address byte slice. Takes the low slice carry as ci.
 * sfix adds FF when the operand byte is a negative offset, so a branch
 * can move back a page. PCH increments only with ld_pc and inc_pc together.
 */
`timescale 1ns/10ps
`default_nettype none

module abh (
    input  logic               clk,
    input  logic               rst_n,
    input  agu_pkg::dp_ctrl_t  ctrl,
    input  agu_pkg::operand_u  db,
    input  logic               ci,
    input  logic [7:0]         reg_val,
    output logic [7:0]         ab_hi
);

    import agu_pkg::*;

    logic [7:0] abh_q;                 // address bus high
    logic [7:0] ahh_q;                 // address hold high
    logic [7:0] pch_q;                 // program counter high
    logic [7:0] sext;                  // sign extension of offset
    logic [7:0] nxt;

    assign sext = (ctrl.sfix && db.rel < 0) ? 8'hff : 8'h00;

    always_comb begin
        case (ctrl.hi_op)
            hi_hold: nxt = abh_q + 8'(ci) + sext;  // page fix on carry or sign
            hi_zero: nxt = reg_val;                // zero page unless loading pc
            hi_pch:  nxt = pch_q;
            default: nxt = ahh_q + 8'(ci);         // abs,X carry into page
        endcase
    end

    assign ab_hi = abh_q;

    always_ff @(posedge clk) begin
        abh_q <= nxt;
        if (ctrl.ld_ahh)
            ahh_q <= db.abs;           // second operand byte
        if (ctrl.ld_pc)
            pch_q <= abh_q + 8'(ctrl.inc_pc & ci);  // ci is PCL carry here
    end

    // sign fix is only defined on top of the held page
    sfix_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.sfix |-> ctrl.hi_op == hi_hold);

endmodule

`default_nettype wire

/* wb_master.sv */
/*
 * Wishbone classic read master, one byte per request, no writes.
 * A request is taken only while idle. rd_data holds until the next ack.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_master (
    input  logic              clk,
    input  logic              rst_n,
    input  agu_pkg::wb_req_t  req,
    output logic              busy,
    output logic              rd_valid,
    output agu_pkg::operand_u rd_data,
    output logic              cyc_o,
    output logic              stb_o,
    output logic              we_o,
    output logic [15:0]       adr_o,
    input  logic [7:0]        dat_i,
    input  logic              ack_i
);

    logic take;                        // accept new request

    assign take = !cyc_o && req.req;
    assign busy = cyc_o;
    assign we_o = 1'b0;                // reads only

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_o    <= 1'b0;
            stb_o    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= stb_o && ack_i;  // one cycle after ack
            if (take) begin
                cyc_o <= 1'b1;
                stb_o <= 1'b1;
            end else if (stb_o && ack_i) begin
                cyc_o <= 1'b0;         // end of cycle
                stb_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            adr_o <= req.adr;
        if (stb_o && ack_i)
            rd_data.abs <= dat_i;
    end

    stb_in_cyc_a: assert property (@(posedge clk) disable iff (!rst_n)
        stb_o |-> cyc_o);

    // address held through wait states
    adr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        stb_o && !ack_i |=> stb_o && $stable(adr_o));

endmodule

`default_nettype wire

/* addr_seq.sv */
/*
 * Addressing mode sequencer. Loads pc into the slices, fetches one or two
 * operand bytes, then composes the effective address on the address bus.
 * start is only honoured while busy is low. ea is valid with done.
 */
`timescale 1ns/10ps
`default_nettype none

module addr_seq (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  agu_pkg::agu_cmd_t  cmd,
    input  logic [15:0]        ab,
    input  logic               rd_valid,
    input  logic               mem_busy,
    output agu_pkg::dp_ctrl_t  ctrl,
    output agu_pkg::wb_req_t   req,
    output logic [15:0]        reg_val,
    output logic               busy,
    output logic               done,
    output logic [15:0]        ea
);

    import agu_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_load, st_f0, st_f1, st_rel, st_br, st_abs, st_fin
    } state_e;

    state_e   state;
    agu_cmd_t cmd_q;                   // command held for the sequence
    logic     issued;                  // bus read outstanding

    assign busy = (state != st_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            issued <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= (state == st_fin);
            if (req.req)
                issued <= 1'b1;
            else if (rd_valid)
                issued <= 1'b0;
            case (state)
                st_idle: if (start) state <= st_load;
                st_load: state <= st_f0;
                st_f0: begin
                    if (rd_valid) begin
                        case (cmd_q.mode)
                            mode_zpx: state <= st_fin;  // composed on the fetch
                            mode_rel: state <= st_rel;
                            default:  state <= st_f1;
                        endcase
                    end
                end
                st_f1:   if (rd_valid) state <= st_abs;
                st_rel:  state <= st_br;
                st_br,
                st_abs:  state <= st_fin;
                default: state <= st_idle;  // st_fin
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start)
            cmd_q <= cmd;
        if (state == st_fin)
            ea <= ab;                  // result landed on the bus
    end

    always_comb begin
        ctrl         = '0;
        ctrl.lo_op   = op_base_abl;    // default holds AB
        ctrl.lo_base = base_zero;
        ctrl.hi_op   = hi_hold;
        reg_val      = {8'h00, cmd_q.x};
        req.req      = 1'b0;
        req.adr      = ab;
        case (state)
            st_load: begin
                ctrl.lo_op = op_reg;   // AB <= pc
                ctrl.hi_op = hi_zero;
                reg_val    = cmd_q.pc;
            end
            st_f0, st_f1: begin
                req.req = !issued && !mem_busy;
                if (rd_valid) begin
                    ctrl.ld_ahl = (state == st_f0);
                    ctrl.ld_ahh = (state == st_f1);
                    if (state == st_f0 && cmd_q.mode == mode_zpx) begin
                        ctrl.lo_op   = op_base_reg;  // db + X, carry dropped
                        ctrl.lo_base = base_db;
                        ctrl.hi_op   = hi_zero;
                    end else begin
                        ctrl.ci     = 1'b1;  // step AB and PC to next byte
                        ctrl.ld_pc  = 1'b1;
                        ctrl.inc_pc = 1'b1;
                    end
                end
            end
            st_rel: begin
                ctrl.ci     = 1'b1;    // pc+2, next instruction
                ctrl.ld_pc  = 1'b1;
                ctrl.inc_pc = 1'b1;
            end
            st_br: begin
                if (cmd_q.cond) begin
                    ctrl.lo_base = base_ahl;  // offset + ABL, page fix in abh
                    ctrl.sfix    = 1'b1;
                end else begin
                    ctrl.lo_op   = op_base;   // not taken, back to PC
                    ctrl.lo_base = base_pcl;
                    ctrl.hi_op   = hi_pch;
                end
            end
            st_abs: begin
                ctrl.lo_op   = (cmd_q.mode == mode_absx) ? op_base_reg : op_base;
                ctrl.lo_base = base_ahl;
                ctrl.hi_op   = hi_ahh;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* agu_top.sv */
/*
 * Address generation unit top. One command at a time, see busy.
 * Bus side is a Wishbone classic read master, byte wide, 16 bit address.
 */
`timescale 1ns/10ps
`default_nettype none

module agu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  agu_pkg::agu_cmd_t cmd,
    output logic              busy,
    output logic              done,
    output logic [15:0]       ea,
    output logic              cyc_o,
    output logic              stb_o,
    output logic              we_o,
    output logic [15:0]       adr_o,
    input  logic [7:0]        dat_i,
    input  logic              ack_i
);

    import agu_pkg::*;

    dp_ctrl_t    ctrl;
    wb_req_t     req;
    operand_u    rd_data;              // DB for both slices
    logic        rd_valid;
    logic        mem_busy;
    logic        co;                   // low to high carry
    logic [7:0]  ab_lo;
    logic [7:0]  ab_hi;
    logic [15:0] reg_val;

    addr_seq addr_seq_i (
        .clk, .rst_n, .start, .cmd,
        .ab       ({ab_hi, ab_lo}),
        .rd_valid, .mem_busy, .ctrl, .req, .reg_val, .busy, .done, .ea
    );

    abl abl_i (
        .clk, .rst_n, .ctrl,
        .db      (rd_data),
        .reg_val (reg_val[7:0]),
        .co,
        .adl     (),
        .ab_lo
    );

    abh abh_i (
        .clk, .rst_n, .ctrl,
        .db      (rd_data),
        .ci      (co),
        .reg_val (reg_val[15:8]),
        .ab_hi
    );

    wb_master wb_master_i (
        .clk, .rst_n, .req,
        .busy     (mem_busy),
        .rd_valid, .rd_data, .cyc_o, .stb_o, .we_o, .adr_o, .dat_i, .ack_i
    );

endmodule

`default_nettype wire

/* tb_wb_mem.sv */
/*
 * Testbench Wishbone classic slave, 64 KiB read only memory.
 * Contents and wait states come from a 32 bit Fibonacci LFSR, seed 41c2.
 * Ack is registered, so a read takes 2 to 5 cycles after stb rises.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic [15:0] adr_i,
    output logic [7:0]  dat_o,
    output logic        ack_o
);

    logic [7:0]  mem [0:65535];
    logic [31:0] dly_lfsr;             // wait state generator
    logic [31:0] dly_next;
    logic [1:0]  delay;                // wait states for this read
    logic [1:0]  cnt;
    logic        armed;                // delay chosen and counting

    // taps 32 22 2 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign dly_next = lfsr_step(lfsr_step(dly_lfsr));  // two bits per delay

    initial begin
        logic [31:0] s;
        ack_o = 1'b0;                  // bus idle before the first clock
        dat_o = 8'h00;
        s = 32'h41c2;
        for (int a = 0; a < 65536; a++) begin
            for (int b = 0; b < 8; b++)
                s = lfsr_step(s);      // one step per bit
            mem[a] = s[7:0];
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ack_o    <= 1'b0;
            armed    <= 1'b0;
            cnt      <= 2'd0;
            delay    <= 2'd0;
            dly_lfsr <= 32'h41c2;
        end else begin
            ack_o <= 1'b0;             // ack is a single cycle pulse
            if (cyc_i && stb_i && !ack_o) begin
                if (!armed) begin
                    dly_lfsr <= dly_next;
                    delay    <= dly_next[1:0];
                    cnt      <= 2'd0;
                    armed    <= 1'b1;
                end else if (cnt == delay) begin
                    ack_o <= 1'b1;
                    dat_o <= mem[adr_i];
                    armed <= 1'b0;
                end else begin
                    cnt <= cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_agu.sv */
/*
 * Testbench for the address generation unit. Random commands come from an LFSR.
 * Expected ea follows the 6502 mode rules over the slave memory contents.
 * Inputs change and outputs are checked on falling edges.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_agu;

    import agu_pkg::*;

    localparam int WAIT_LIMIT = 100;   // cycles per wait loop

    logic        clk;
    logic        rst_n;
    logic        start;
    agu_cmd_t    cmd;
    logic        busy;
    logic        done;
    logic [15:0] ea;
    logic        cyc_o;
    logic        stb_o;
    logic        we_o;
    logic [15:0] adr_o;
    logic [7:0]  wb_dat;
    logic        wb_ack;

    logic [31:0] lfsr_q = 32'h41c2;    // stimulus generator
    logic [15:0] exp_ea;
    logic [15:0] exp_pc;
    int          exp_fetches = 0;
    int          fetch_n = 0;          // reads seen in this command
    int          sent = 0;
    int          checked = 0;
    int          zp_wraps = 0;
    int          abs_carries = 0;
    int          fwd_cross = 0;
    int          back_cross = 0;

    agu_top agu_top_i (
        .clk, .rst_n, .start, .cmd, .busy, .done, .ea,
        .cyc_o, .stb_o, .we_o, .adr_o,
        .dat_i (wb_dat),
        .ack_i (wb_ack)
    );

    tb_wb_mem mem_i (
        .clk, .rst_n,
        .cyc_i (cyc_o),
        .stb_i (stb_o),
        .adr_i (adr_o),
        .dat_o (wb_dat),
        .ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        for (int i = 0; i < n; i++)
            lfsr_q = lfsr_step(lfsr_q);    // one step per bit
        v = lfsr_q & ((32'd1 << n) - 32'd1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_low(input string name, input logic val);
        assert (val == 1'b0) else
            abort_run($sformatf("mismatch at %0t: %s got %b expected 0", $time, name, val));
    endtask

    // effective address straight from the addressing mode rules
    function automatic logic [15:0] ref_ea(input agu_cmd_t c);
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [15:0] next_pc;
        b0      = mem_i.mem[c.pc];
        b1      = mem_i.mem[c.pc + 16'd1];  // wraps past FFFF
        next_pc = c.pc + 16'd2;
        case (c.mode)
            mode_zpx:  ref_ea = {8'h00, b0 + c.x};  // stays in page zero
            mode_abs:  ref_ea = {b1, b0};
            mode_absx: ref_ea = {b1, b0} + {8'h00, c.x};
            default:   ref_ea = c.cond ? next_pc + {{8{b0[7]}}, b0} : next_pc;
        endcase
    endfunction

    task automatic run_cmd(input agu_mode_e mode, input logic [15:0] pc,
                           input logic [7:0] x, input logic cond);
        agu_cmd_t    c;
        logic [15:0] next_pc;
        int          n;
        c.mode  = mode;
        c.pc    = pc;
        c.x     = x;
        c.cond  = cond;
        next_pc = pc + 16'd2;
        @(negedge clk);
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (!busy) else abort_run("DUT stayed busy and never accepted a command");
        if (sent > 0) begin
            assert (ea == exp_ea) else
                abort_run($sformatf("mismatch at %0t: ea got %h expected %h",
                                    $time, ea, exp_ea));
        end
        exp_ea      = ref_ea(c);
        exp_pc      = pc;
        exp_fetches = (mode == mode_abs || mode == mode_absx) ? 2 : 1;
        case (mode)
            mode_zpx:  if (exp_ea[7:0] < x) zp_wraps++;
            mode_absx: if (exp_ea[7:0] < x) abs_carries++;
            mode_rel: begin
                if (cond && exp_ea[15:8] == next_pc[15:8] + 8'd1)
                    fwd_cross++;
                else if (cond && exp_ea[15:8] == next_pc[15:8] - 8'd1)
                    back_cross++;
            end
            default: ;
        endcase
        cmd   = c;
        start = 1'b1;                  // one cycle pulse
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            assert (busy) else
                abort_run($sformatf("mismatch at %0t: busy got %b expected 1", $time, busy));
            @(negedge clk);
            n++;
        end
        assert (done) else abort_run("timeout waiting for done from the DUT");
        sent++;
    endtask

    task automatic run_random(input agu_mode_e mode, input int count,
                              input logic page_end);
        logic [31:0] r;
        logic [15:0] pc;
        for (int i = 0; i < count; i++) begin
            draw_bits(16, r);
            pc = page_end ? {r[15:8], 8'hff} : r[15:0];  // byte 1 on next page
            draw_bits(9, r);
            run_cmd(mode, pc, r[7:0], r[8]);
        end
    endtask

    // bus monitor and result checker
    always @(negedge clk) begin
        if (cyc_o) begin
            assert (!we_o) else
                abort_run($sformatf("mismatch at %0t: we_o got %b expected 0", $time, we_o));
        end
        if (stb_o && wb_ack) begin
            assert (adr_o == exp_pc + 16'(fetch_n)) else
                abort_run($sformatf("mismatch at %0t: adr_o got %h expected %h",
                                    $time, adr_o, exp_pc + 16'(fetch_n)));
            fetch_n = fetch_n + 1;
        end
        if (done) begin
            assert (ea == exp_ea) else
                abort_run($sformatf("mismatch at %0t: ea got %h expected %h",
                                    $time, ea, exp_ea));
            assert (fetch_n == exp_fetches) else
                abort_run($sformatf("mismatch at %0t: bus reads got %0d expected %0d",
                                    $time, fetch_n, exp_fetches));
            fetch_n = 0;
            checked = checked + 1;
        end
    end

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        cmd   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // quiet after reset
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_low("cyc_o", cyc_o);
            check_low("stb_o", stb_o);
            check_low("busy", busy);
            check_low("done", done);
        end
        run_random(mode_zpx, 100, 1'b0);
        run_random(mode_abs, 60, 1'b0);
        run_random(mode_absx, 80, 1'b0);
        run_random(mode_rel, 300, 1'b0);
        run_random(mode_zpx, 8, 1'b1);
        run_random(mode_abs, 8, 1'b1);
        run_random(mode_absx, 8, 1'b1);
        run_random(mode_rel, 16, 1'b1);
        run_cmd(mode_zpx, 16'hffff, 8'h80, 1'b0);  // top of memory
        run_cmd(mode_abs, 16'hffff, 8'h00, 1'b0);
        run_cmd(mode_absx, 16'hffff, 8'hff, 1'b0);
        run_cmd(mode_rel, 16'hffff, 8'h00, 1'b1);
        @(negedge clk);
        if (checked == sent && zp_wraps > 0 && abs_carries > 0 &&
            fwd_cross > 0 && back_cross > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run($sformatf("results %0d of %0d or a corner case never hit (%0d %0d %0d %0d)",
                                checked, sent, zp_wraps, abs_carries, fwd_cross, back_cross));
        end
    end

endmodule

`default_nettype wire

/* src.f */
agu_pkg.sv
abl.sv
abh.sv
wb_master.sv
addr_seq.sv
agu_top.sv
tb_wb_mem.sv
tb_agu.sv

/* run.sh */
#!/bin/sh
# Build the AGU testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps -f src.f --top-module tb_agu \
    --Mdir obj_dir -o tb_agu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_agu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi
exit "$status"
